// ==== defs.sv ====
package defs;

    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // major opcode groups of rv32i.
    typedef enum logic [6:0] {
        LOAD           = 7'b0000011,
        STORE          = 7'b0100011,
        ARITHMETIC_IMM = 7'b0010011,
        ARITHMETIC_REG = 7'b0110011,
        BRANCH         = 7'b1100011,
        JAL            = 7'b1101111,
        JALR           = 7'b1100111,
        AUIPC          = 7'b0010111,
        LUI            = 7'b0110111
    } opcode_t;

    typedef enum logic [2:0] {
        IMM_I_TYPE,
        IMM_S_TYPE,
        IMM_B_TYPE,
        IMM_U_TYPE,
        IMM_J_TYPE,
        IMM_UNKNOWN
    } imm_sel_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASSB
    } alu_op_t;

    // value of a field that the format does not carry.
    localparam reg_addr_t REG_UNKNOWN    = '0;
    localparam funct3_t   FUNCT3_UNKNOWN = '0;
    localparam funct7_t   FUNCT7_UNKNOWN = '0;

endpackage

// ==== imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen
    import defs::*;
(
    input  imm_sel_t    imm_sel_c,
    input  logic [24:0] imm_i,
    output data_t       imm_o
);

    // imm_i[k] holds instruction bit k+7.
    always_comb begin
        case (imm_sel_c)
            IMM_I_TYPE: begin
                imm_o = {{20{imm_i[24]}}, imm_i[24:13]};
            end
            IMM_S_TYPE: begin
                imm_o = {{20{imm_i[24]}}, imm_i[24:18], imm_i[4:0]};
            end
            IMM_B_TYPE: begin
                imm_o = {{20{imm_i[24]}}, imm_i[0], imm_i[23:18], imm_i[4:1], 1'b0};
            end
            IMM_U_TYPE: begin
                imm_o = {imm_i[24:5], 12'b0};
            end
            IMM_J_TYPE: begin
                imm_o = {{12{imm_i[24]}}, imm_i[12:5], imm_i[13], imm_i[23:14], 1'b0};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

// ==== id.sv ====
`timescale 1ns/1ps

module id
    import defs::*;
(
    input  data_t     instruction_i,
    output opcode_t   op_o,
    output reg_addr_t rd_o,
    output reg_addr_t rs1_o,
    output reg_addr_t rs2_o,
    output funct3_t   funct3_o,
    output funct7_t   funct7_o,
    output data_t     imm_o
);

    opcode_t  op;
    imm_sel_t imm_sel;
    logic     has_rd;
    logic     has_rs1;
    logic     has_rs2;
    logic     has_f3;
    logic     has_f7;

    assign op = opcode_t'(instruction_i[6:0]);

    // which fields exist depends on the instruction format.
    always_comb begin
        imm_sel = IMM_UNKNOWN;
        has_rd  = 1'b0;
        has_rs1 = 1'b0;
        has_rs2 = 1'b0;
        has_f3  = 1'b0;
        has_f7  = 1'b0;
        case (op)
            LOAD, ARITHMETIC_IMM, JALR: begin
                imm_sel = IMM_I_TYPE;
                has_rd  = 1'b1;
                has_rs1 = 1'b1;
                has_f3  = 1'b1;
            end
            STORE: begin
                imm_sel = IMM_S_TYPE;
                has_rs1 = 1'b1;
                has_rs2 = 1'b1;
                has_f3  = 1'b1;
            end
            BRANCH: begin
                imm_sel = IMM_B_TYPE;
                has_rs1 = 1'b1;
                has_rs2 = 1'b1;
                has_f3  = 1'b1;
            end
            ARITHMETIC_REG: begin
                has_rd  = 1'b1;
                has_rs1 = 1'b1;
                has_rs2 = 1'b1;
                has_f3  = 1'b1;
                has_f7  = 1'b1;
            end
            JAL: begin
                imm_sel = IMM_J_TYPE;
                has_rd  = 1'b1;
            end
            AUIPC, LUI: begin
                imm_sel = IMM_U_TYPE;
                has_rd  = 1'b1;
            end
            default: begin
                imm_sel = IMM_UNKNOWN;
            end
        endcase
    end

    assign op_o     = op;
    assign rd_o     = has_rd  ? reg_addr_t'(instruction_i[11:7])  : REG_UNKNOWN;
    assign rs1_o    = has_rs1 ? reg_addr_t'(instruction_i[19:15]) : REG_UNKNOWN;
    assign rs2_o    = has_rs2 ? reg_addr_t'(instruction_i[24:20]) : REG_UNKNOWN;
    assign funct3_o = has_f3  ? funct3_t'(instruction_i[14:12])   : FUNCT3_UNKNOWN;
    assign funct7_o = has_f7  ? funct7_t'(instruction_i[31:25])   : FUNCT7_UNKNOWN;

    imm_gen u_imm_gen (
        .imm_sel_c (imm_sel),
        .imm_i     (instruction_i[31:7]),
        .imm_o     (imm_o)
    );

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file
    import defs::*;
#(
    parameter int NREGS = 32
) (
    input  logic      clk_i,
    input  logic      rst_i,
    input  reg_addr_t ra1_i,
    input  reg_addr_t ra2_i,
    output data_t     rd1_o,
    output data_t     rd2_o,
    input  logic      we_i,
    input  reg_addr_t wa_i,
    input  data_t     wd_i
);

    localparam int AW = $clog2(NREGS);

    data_t regs [NREGS];

    // x0 and indices past the end read as zero.
    assign rd1_o = (ra1_i != '0 && int'(ra1_i) < NREGS) ? regs[ra1_i[AW-1:0]] : '0;
    assign rd2_o = (ra2_i != '0 && int'(ra2_i) < NREGS) ? regs[ra2_i[AW-1:0]] : '0;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wa_i != '0 && int'(wa_i) < NREGS) begin
            regs[wa_i[AW-1:0]] <= wd_i;
        end
    end

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps

module alu
    import defs::*;
(
    input  alu_op_t op_i,
    input  data_t   a_i,
    input  data_t   b_i,
    output data_t   y_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:   y_o = a_i + b_i;
            ALU_SUB:   y_o = a_i - b_i;
            ALU_SLL:   y_o = a_i << shamt;
            ALU_SLT:   y_o = {31'b0, $signed(a_i) < $signed(b_i)};
            ALU_SLTU:  y_o = {31'b0, a_i < b_i};
            ALU_XOR:   y_o = a_i ^ b_i;
            ALU_SRL:   y_o = a_i >> shamt;
            ALU_SRA:   y_o = data_t'($signed(a_i) >>> shamt);
            ALU_OR:    y_o = a_i | b_i;
            ALU_AND:   y_o = a_i & b_i;
            // lui goes through here.
            ALU_PASSB: y_o = b_i;
            default:   y_o = '0;
        endcase
    end

endmodule

// ==== issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage
    import defs::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      in_valid_i,
    output logic      in_ready_o,
    input  data_t     pc_i,
    input  opcode_t   op_i,
    input  reg_addr_t rd_i,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    input  funct3_t   funct3_i,
    input  funct7_t   funct7_i,
    input  data_t     imm_i,
    input  data_t     rd1_i,
    input  data_t     rd2_i,
    input  reg_addr_t fwd_rd_i,
    input  logic      fwd_we_i,
    input  data_t     fwd_data_i,
    input  logic      out_ready_i,
    output logic      s1_valid_o,
    output opcode_t   s1_op_o,
    output reg_addr_t s1_rd_o,
    output logic      s1_we_o,
    output alu_op_t   s1_alu_op_o,
    output data_t     s1_a_o,
    output data_t     s1_b_o,
    output data_t     s1_rs1v_o,
    output data_t     s1_rs2v_o,
    output data_t     s1_imm_o,
    output data_t     s1_pc_o,
    output funct3_t   s1_funct3_o
);

    logic    load_en;
    data_t   rs1v;
    data_t   rs2v;
    data_t   a_d;
    data_t   b_d;
    alu_op_t alu_op_d;
    logic    we_d;

    function automatic alu_op_t arith_op(funct3_t f3, logic alt);
        case (f3)
            3'b000:  arith_op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    endfunction

    assign in_ready_o = !s1_valid_o || out_ready_i;
    assign load_en    = in_valid_i && in_ready_o;

    // the result of the instruction ahead is not yet in the register file.
    assign rs1v = (fwd_we_i && fwd_rd_i != '0 && fwd_rd_i == rs1_i) ? fwd_data_i : rd1_i;
    assign rs2v = (fwd_we_i && fwd_rd_i != '0 && fwd_rd_i == rs2_i) ? fwd_data_i : rd2_i;

    always_comb begin
        a_d      = rs1v;
        b_d      = imm_i;
        alu_op_d = ALU_ADD;
        we_d     = rd_i != '0;
        case (op_i)
            ARITHMETIC_REG: begin
                b_d      = rs2v;
                alu_op_d = arith_op(funct3_i, funct7_i[5]);
            end
            ARITHMETIC_IMM: begin
                // only srai uses the alternate encoding.
                alu_op_d = arith_op(funct3_i, imm_i[10] && funct3_i == 3'b101);
            end
            JAL, JALR: begin
                a_d = pc_i;
                b_d = 32'd4;
            end
            AUIPC: begin
                a_d = pc_i;
            end
            LUI: begin
                alu_op_d = ALU_PASSB;
            end
            LOAD: begin
                alu_op_d = ALU_ADD;
            end
            STORE, BRANCH: begin
                we_d = 1'b0;
            end
            default: begin
                a_d  = '0;
                b_d  = '0;
                we_d = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            s1_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            s1_valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_en) begin
            s1_op_o     <= op_i;
            s1_rd_o     <= rd_i;
            s1_we_o     <= we_d;
            s1_alu_op_o <= alu_op_d;
            s1_a_o      <= a_d;
            s1_b_o      <= b_d;
            s1_rs1v_o   <= rs1v;
            s1_rs2v_o   <= rs2v;
            s1_imm_o    <= imm_i;
            s1_pc_o     <= pc_i;
            s1_funct3_o <= funct3_i;
        end
    end

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage
    import defs::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      s1_valid_i,
    output logic      s1_ready_o,
    input  opcode_t   s1_op_i,
    input  reg_addr_t s1_rd_i,
    input  logic      s1_we_i,
    input  alu_op_t   s1_alu_op_i,
    input  data_t     s1_a_i,
    input  data_t     s1_b_i,
    input  data_t     s1_rs1v_i,
    input  data_t     s1_rs2v_i,
    input  data_t     s1_imm_i,
    input  data_t     s1_pc_i,
    input  funct3_t   s1_funct3_i,
    output reg_addr_t fwd_rd_o,
    output logic      fwd_we_o,
    output data_t     fwd_data_o,
    output logic      rf_we_o,
    output reg_addr_t rf_wa_o,
    output data_t     rf_wd_o,
    output logic      retire_valid_o,
    input  logic      retire_ready_i,
    output data_t     retire_pc_o,
    output reg_addr_t retire_rd_o,
    output logic      retire_we_o,
    output data_t     retire_data_o
);

    logic  capture;
    logic  taken;
    data_t alu_y;
    data_t result;

    alu u_alu (
        .op_i (s1_alu_op_i),
        .a_i  (s1_a_i),
        .b_i  (s1_b_i),
        .y_o  (alu_y)
    );

    always_comb begin
        case (s1_funct3_i)
            3'b000:  taken = s1_rs1v_i == s1_rs2v_i;
            3'b001:  taken = s1_rs1v_i != s1_rs2v_i;
            3'b100:  taken = $signed(s1_rs1v_i) < $signed(s1_rs2v_i);
            3'b101:  taken = $signed(s1_rs1v_i) >= $signed(s1_rs2v_i);
            3'b110:  taken = s1_rs1v_i < s1_rs2v_i;
            3'b111:  taken = s1_rs1v_i >= s1_rs2v_i;
            default: taken = 1'b0;
        endcase
    end

    assign result = (s1_op_i == BRANCH) ? {31'b0, taken} : alu_y;

    assign s1_ready_o = !retire_valid_o || retire_ready_i;
    assign capture    = s1_valid_i && s1_ready_o;

    assign fwd_rd_o   = s1_rd_i;
    assign fwd_we_o   = s1_valid_i && s1_we_i;
    assign fwd_data_o = result;

    // write happens on the same edge the record is captured.
    assign rf_we_o = capture && s1_we_i;
    assign rf_wa_o = s1_rd_i;
    assign rf_wd_o = result;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            retire_valid_o <= 1'b0;
        end else if (s1_ready_o) begin
            retire_valid_o <= s1_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            retire_pc_o   <= s1_pc_i;
            retire_rd_o   <= s1_rd_i;
            retire_we_o   <= s1_we_i;
            retire_data_o <= result;
        end
    end

endmodule

// ==== rv32i_exec.sv ====
`timescale 1ns/1ps

module rv32i_exec
    import defs::*;
#(
    parameter int NREGS = 32
) (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      instr_valid_i,
    output logic      instr_ready_o,
    input  data_t     instr_i,
    input  data_t     pc_i,
    output logic      retire_valid_o,
    input  logic      retire_ready_i,
    output data_t     retire_pc_o,
    output reg_addr_t retire_rd_o,
    output logic      retire_we_o,
    output data_t     retire_data_o
);

    opcode_t   dec_op;
    reg_addr_t dec_rd;
    reg_addr_t dec_rs1;
    reg_addr_t dec_rs2;
    funct3_t   dec_funct3;
    funct7_t   dec_funct7;
    data_t     dec_imm;

    data_t     rf_rd1;
    data_t     rf_rd2;
    logic      rf_we;
    reg_addr_t rf_wa;
    data_t     rf_wd;

    reg_addr_t fwd_rd;
    logic      fwd_we;
    data_t     fwd_data;

    logic      s1_valid;
    logic      s1_ready;
    opcode_t   s1_op;
    reg_addr_t s1_rd;
    logic      s1_we;
    alu_op_t   s1_alu_op;
    data_t     s1_a;
    data_t     s1_b;
    data_t     s1_rs1v;
    data_t     s1_rs2v;
    data_t     s1_imm;
    data_t     s1_pc;
    funct3_t   s1_funct3;

    id u_id (
        .instruction_i (instr_i),
        .op_o          (dec_op),
        .rd_o          (dec_rd),
        .rs1_o         (dec_rs1),
        .rs2_o         (dec_rs2),
        .funct3_o      (dec_funct3),
        .funct7_o      (dec_funct7),
        .imm_o         (dec_imm)
    );

    reg_file #(
        .NREGS (NREGS)
    ) u_reg_file (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .ra1_i (dec_rs1),
        .ra2_i (dec_rs2),
        .rd1_o (rf_rd1),
        .rd2_o (rf_rd2),
        .we_i  (rf_we),
        .wa_i  (rf_wa),
        .wd_i  (rf_wd)
    );

    issue_stage u_issue (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .in_valid_i  (instr_valid_i),
        .in_ready_o  (instr_ready_o),
        .pc_i        (pc_i),
        .op_i        (dec_op),
        .rd_i        (dec_rd),
        .rs1_i       (dec_rs1),
        .rs2_i       (dec_rs2),
        .funct3_i    (dec_funct3),
        .funct7_i    (dec_funct7),
        .imm_i       (dec_imm),
        .rd1_i       (rf_rd1),
        .rd2_i       (rf_rd2),
        .fwd_rd_i    (fwd_rd),
        .fwd_we_i    (fwd_we),
        .fwd_data_i  (fwd_data),
        .out_ready_i (s1_ready),
        .s1_valid_o  (s1_valid),
        .s1_op_o     (s1_op),
        .s1_rd_o     (s1_rd),
        .s1_we_o     (s1_we),
        .s1_alu_op_o (s1_alu_op),
        .s1_a_o      (s1_a),
        .s1_b_o      (s1_b),
        .s1_rs1v_o   (s1_rs1v),
        .s1_rs2v_o   (s1_rs2v),
        .s1_imm_o    (s1_imm),
        .s1_pc_o     (s1_pc),
        .s1_funct3_o (s1_funct3)
    );

    execute_stage u_execute (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .s1_valid_i     (s1_valid),
        .s1_ready_o     (s1_ready),
        .s1_op_i        (s1_op),
        .s1_rd_i        (s1_rd),
        .s1_we_i        (s1_we),
        .s1_alu_op_i    (s1_alu_op),
        .s1_a_i         (s1_a),
        .s1_b_i         (s1_b),
        .s1_rs1v_i      (s1_rs1v),
        .s1_rs2v_i      (s1_rs2v),
        .s1_imm_i       (s1_imm),
        .s1_pc_i        (s1_pc),
        .s1_funct3_i    (s1_funct3),
        .fwd_rd_o       (fwd_rd),
        .fwd_we_o       (fwd_we),
        .fwd_data_o     (fwd_data),
        .rf_we_o        (rf_we),
        .rf_wa_o        (rf_wa),
        .rf_wd_o        (rf_wd),
        .retire_valid_o (retire_valid_o),
        .retire_ready_i (retire_ready_i),
        .retire_pc_o    (retire_pc_o),
        .retire_rd_o    (retire_rd_o),
        .retire_we_o    (retire_we_o),
        .retire_data_o  (retire_data_o)
    );

endmodule

// ==== rv32i_exec_checker.sv ====
`timescale 1ns/1ps

module rv32i_exec_checker (
    input logic        clk_i,
    input logic        rst_i,
    input logic        valid_i,
    input logic        ready_i,
    input logic [31:0] pc_i,
    input logic [4:0]  rd_i,
    input logic        we_i,
    input logic [31:0] data_i
);

    // a stalled retire record holds until it is taken.
    a_retire_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        valid_i && !ready_i |=> valid_i && $stable(pc_i) && $stable(rd_i)
                                && $stable(we_i) && $stable(data_i))
        else $error("retire record changed while stalled");

    a_reset_idle: assert property (@(posedge clk_i) rst_i |=> !valid_i)
        else $error("retire valid high after reset");

    a_no_x0_write: assert property (@(posedge clk_i) disable iff (rst_i)
        valid_i && we_i |-> rd_i != 5'd0)
        else $error("retire reports a write to x0");

endmodule

bind rv32i_exec rv32i_exec_checker u_checker (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (retire_valid_o),
    .ready_i (retire_ready_i),
    .pc_i    (retire_pc_o),
    .rd_i    (retire_rd_o),
    .we_i    (retire_we_o),
    .data_i  (retire_data_o)
);

// ==== tb_rv32i_exec.sv ====
`timescale 1ns/1ps

module tb_rv32i_exec
    import defs::*;
();

    localparam int KIND_ARITH = 0;
    localparam int KIND_UPPER = 1;
    localparam int KIND_MEM   = 2;
    localparam int KIND_CHAIN = 3;
    localparam int KIND_STALL = 4;
    localparam int KIND_ZERO  = 5;

    logic      clk_i;
    logic      rst_i;
    logic      instr_valid_i;
    logic      instr_ready_o;
    data_t     instr_i;
    data_t     pc_i;
    logic      retire_valid_o;
    logic      retire_ready_i;
    data_t     retire_pc_o;
    reg_addr_t retire_rd_o;
    logic      retire_we_o;
    data_t     retire_data_o;

    logic [31:0] lfsr = 32'he86d754a;
    logic [4:0]  chain_rd = 5'd1;
    logic [31:0] model_regs [32];
    // expected record is {pc, rd, we, data}.
    logic [69:0] exp_q [$];
    int          errors = 0;
    int          checks = 0;
    logic        timed_out = 1'b0;

    rv32i_exec #(
        .NREGS (32)
    ) uut (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .instr_valid_i  (instr_valid_i),
        .instr_ready_o  (instr_ready_o),
        .instr_i        (instr_i),
        .pc_i           (pc_i),
        .retire_valid_o (retire_valid_o),
        .retire_ready_i (retire_ready_i),
        .retire_pc_o    (retire_pc_o),
        .retire_rd_o    (retire_rd_o),
        .retire_we_o    (retire_we_o),
        .retire_data_o  (retire_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        int          i;
        v = 32'd0;
        for (i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic opcode_t group_at(input int n);
        case (n)
            0:       return ARITHMETIC_REG;
            1:       return ARITHMETIC_IMM;
            2:       return LUI;
            3:       return AUIPC;
            4:       return JAL;
            5:       return JALR;
            6:       return BRANCH;
            7:       return LOAD;
            default: return STORE;
        endcase
    endfunction

    function automatic logic [31:0] encode(input opcode_t opc, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [2:0] f3, input logic [19:0] hi);
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [2:0]  mf3;
        logic [2:0]  bf3;
        imm = hi[11:0];
        mf3 = (f3[1:0] == 2'b11) ? 3'b010 : {1'b0, f3[1:0]};
        // funct3 values 2 and 3 are not branches.
        bf3 = (f3[2:1] == 2'b01) ? (f3 | 3'b100) : f3;
        case (opc)
            ARITHMETIC_REG: begin
                f7 = ((f3 == 3'b000 || f3 == 3'b101) && hi[0]) ? 7'h20 : 7'h00;
                return {f7, rs2, rs1, f3, rd, opc};
            end
            ARITHMETIC_IMM: begin
                if (f3 == 3'b001) begin
                    imm[11:5] = 7'h00;
                end else if (f3 == 3'b101) begin
                    imm[11:5] = hi[12] ? 7'h20 : 7'h00;
                end
                return {imm, rs1, f3, rd, opc};
            end
            JALR:    return {imm, rs1, 3'b000, rd, opc};
            LOAD:    return {imm, rs1, mf3, rd, opc};
            STORE:   return {imm[11:5], rs2, rs1, mf3, imm[4:0], opc};
            BRANCH:  return {imm[11:5], rs2, rs1, bf3, imm[4:0], opc};
            default: return {hi, rd, opc};
        endcase
    endfunction

    function automatic logic [31:0] make_instr(input int kind);
        opcode_t     opc;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [19:0] hi;
        int          sel;
        rd  = 5'(rand_bits(5));
        rs1 = 5'(rand_bits(5));
        rs2 = 5'(rand_bits(5));
        f3  = 3'(rand_bits(3));
        hi  = 20'(rand_bits(20));
        sel = int'(rand_bits(8));
        case (kind)
            KIND_ARITH: opc = group_at(sel % 2);
            KIND_UPPER: opc = group_at(2 + sel % 4);
            KIND_MEM:   opc = group_at(6 + sel % 3);
            KIND_CHAIN: begin
                opc = (sel % 3 == 2) ? LOAD : group_at(sel % 2);
                rs1 = chain_rd;
                rs2 = chain_rd;
                if (rd == 5'd0) begin
                    rd = 5'd1;
                end
                chain_rd = rd;
            end
            KIND_ZERO: begin
                opc = group_at(sel % 3);
                if (sel[3]) begin
                    rd = 5'd0;
                end
                if (sel[4]) begin
                    rs1 = 5'd0;
                    rs2 = 5'd0;
                end
            end
            default: opc = group_at(sel % 9);
        endcase
        return encode(opc, rd, rs1, rs2, f3, hi);
    endfunction

    function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'd0, $signed(a) < $signed(b)};
            3'b011:  return {31'd0, a < b};
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return sa >>> b[4:0];
                end else begin
                    return a >> b[4:0];
                end
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // architectural effect of one accepted instruction, in program order.
    task automatic model_accept(input logic [31:0] ins, input logic [31:0] pc);
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_itype;
        logic [31:0] data;
        logic        we;
        rd        = ins[11:7];
        f3        = ins[14:12];
        a         = model_regs[ins[19:15]];
        b         = model_regs[ins[24:20]];
        imm_itype = {{20{ins[31]}}, ins[31:20]};
        we        = rd != 5'd0;
        data      = 32'd0;
        case (opcode_t'(ins[6:0]))
            ARITHMETIC_REG: data = arith(f3, ins[30], a, b);
            ARITHMETIC_IMM: data = arith(f3, ins[30] && f3 == 3'b101, a, imm_itype);
            LUI:            data = {ins[31:12], 12'd0};
            AUIPC:          data = pc + {ins[31:12], 12'd0};
            JAL, JALR:      data = pc + 32'd4;
            LOAD:           data = a + imm_itype;
            STORE: begin
                rd   = 5'd0;
                we   = 1'b0;
                data = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            end
            BRANCH: begin
                rd   = 5'd0;
                we   = 1'b0;
                data = {31'd0, branch_taken(f3, a, b)};
            end
            default: begin
                rd = 5'd0;
                we = 1'b0;
            end
        endcase
        if (we) begin
            model_regs[rd] = data;
        end
        exp_q.push_back({pc, rd, we, data});
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp,
                           input logic [31:0] pc);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERROR %0s: got %h, expected %h, pc %h", name, got, exp, pc);
        end
    endtask

    task automatic check_retire();
        logic [69:0] rec;
        if (exp_q.size() == 0) begin
            errors++;
            $display("retire record at pc %h arrived with no instruction outstanding",
                     retire_pc_o);
        end else begin
            rec = exp_q.pop_front();
            compare("retire_pc_o", retire_pc_o, rec[69:38], rec[69:38]);
            compare("retire_rd_o", 32'(retire_rd_o), 32'(rec[37:33]), rec[69:38]);
            compare("retire_we_o", 32'(retire_we_o), 32'(rec[32]), rec[69:38]);
            compare("retire_data_o", retire_data_o, rec[31:0], rec[69:38]);
        end
    endtask

    task automatic run_test(input string name, input int kind, input int count,
                            input logic stall);
        int issued;
        int retired;
        int cycles;
        int limit;
        int errs_before;
        if (!timed_out) begin
            issued      = 0;
            retired     = 0;
            cycles      = 0;
            limit       = 8 * count;
            errs_before = errors;
            @(posedge clk_i);
            instr_i        <= make_instr(kind);
            pc_i           <= rand_bits(30) << 2;
            instr_valid_i  <= 1'b1;
            retire_ready_i <= stall ? 1'(rand_bits(1)) : 1'b1;
            while (retired < count && cycles < limit) begin
                @(posedge clk_i);
                cycles++;
                // with retire always ready the input port takes one instruction per cycle.
                if (!stall && instr_valid_i) begin
                    compare("instr_ready_o", 32'(instr_ready_o), 32'd1, pc_i);
                end
                if (instr_valid_i && instr_ready_o) begin
                    model_accept(instr_i, pc_i);
                    issued++;
                    if (issued < count) begin
                        instr_i <= make_instr(kind);
                        pc_i    <= rand_bits(30) << 2;
                    end else begin
                        instr_valid_i <= 1'b0;
                    end
                end
                if (retire_valid_o && retire_ready_i) begin
                    check_retire();
                    retired++;
                end
                retire_ready_i <= stall ? 1'(rand_bits(1)) : 1'b1;
            end
            if (retired < count) begin
                timed_out = 1'b1;
                $display("timeout in test %0s after %0d cycles, %0d of %0d retired",
                         name, cycles, retired, count);
            end else begin
                // nothing may retire once the last record is out.
                @(posedge clk_i);
                checks++;
                if (retire_valid_o || retired != issued || exp_q.size() != 0) begin
                    errors++;
                    $display("retire count %0d and issue count %0d disagree in test %0s",
                             retired, issued, name);
                end
            end
            $display("test %0s: %0d instructions, %0d errors", name, count,
                     errors - errs_before);
        end
    endtask

    initial begin
        int r;
        rst_i          = 1'b1;
        instr_valid_i  = 1'b0;
        instr_i        = 32'd0;
        pc_i           = 32'd0;
        retire_ready_i = 1'b0;
        for (r = 0; r < 32; r++) begin
            model_regs[r] = 32'd0;
        end
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;
        run_test("arithmetic", KIND_ARITH, 300, 1'b0);
        run_test("upper_and_jump", KIND_UPPER, 60, 1'b0);
        run_test("branch_and_memory", KIND_MEM, 90, 1'b0);
        run_test("forwarding_chain", KIND_CHAIN, 100, 1'b0);
        run_test("back_pressure", KIND_STALL, 200, 1'b1);
        run_test("x0", KIND_ZERO, 60, 1'b0);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
defs.sv
imm_gen.sv
id.sv
reg_file.sv
alu.sv
issue_stage.sv
execute_stage.sv
rv32i_exec.sv
rv32i_exec_checker.sv
tb_rv32i_exec.sv

// ==== Makefile ====
TOP = tb_rv32i_exec

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Result: PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
